/* all.f */
+incdir+design
design/photon_pkg.sv
design/edge_detect.sv
design/pulse_counter.sv
design/record_fifo.sv
design/frame_buffer.sv
design/photon_counter_top.sv
verification/photon_counter_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= photon_counter_tb
FLAGS     ?= --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* verification/photon_counter_tb.sv */
`timescale 1ns/100ps
`include "photon_params.svh"

module photon_counter_tb;

    import photon_pkg::*;

    localparam int ENTRIES         = 1 << `PH_BUF_AW;
    localparam int COUNT_MAX       = (1 << `PH_COUNT_W) - 1;
    localparam int RANDOM_PERIODS  = 20;
    localparam int FREEZE_PERIODS  = 6;
    localparam int NUM_PERIODS     = RANDOM_PERIODS + 1 + FREEZE_PERIODS;
    localparam int WATCHDOG_CYCLES = NUM_PERIODS * 200 + 2000;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           photon_pulse;
    logic           sync_in;
    logic           freeze;
    logic           pixel_valid;
    display_pixel_t pixel;
    logic           overflow;
    logic           sync_fall;

    //////////////////////////////////////////////////////////////////////
    // Reference model state.
    //////////////////////////////////////////////////////////////////////

    logic [`PH_COUNT_W-1:0] exp_count  [ENTRIES] = '{default: '0};  // Shown counts.
    logic                   exp_filled [ENTRIES] = '{default: 1'b0};
    logic [`PH_COUNT_W-1:0] sent_count [NUM_PERIODS] = '{default: '0};  // Per frame.
    logic                   sent_valid [NUM_PERIODS] = '{default: 1'b0};  // Not dropped.
    logic                   shown      [NUM_PERIODS] = '{default: 1'b0};  // Seen on display.
    int                     frames_sent = 0;   // Sync edges driven so far.
    int                     pixel_count = 0;
    int                     fall_count  = 0;
    logic [`PH_BUF_AW-1:0]  prev_addr   = '0;
    string                  test_name   = "reset";

    photon_counter_top photon_counter_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .photon_pulse (photon_pulse),
        .sync_in      (sync_in),
        .freeze       (freeze),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel),
        .overflow     (overflow),
        .sync_fall    (sync_fall)
    );

    always #20 clk = ~clk;  // 40 ns period.

    //////////////////////////////////////////////////////////////////////
    // Error output.
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_error(input string line);
        $display("TEST FAILED");
        $display("%s", line);
        $fatal(1, "Run stopped at the first error.");
    endtask

    function automatic string mismatch_line(input string test, input string exp_txt,
                                            input string act_txt);
        return $sformatf("Mismatch %s expected %s actual %s", test, exp_txt, act_txt);
    endfunction

    function automatic string pixel_text(input logic f, input logic [`PH_COUNT_W-1:0] c);
        return $sformatf("filled=%0b,count=%0d", f, c);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus.
    //////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #2;  // Inputs move just after the edge.
    endtask

    // Photon pulses 3 cycles high and 6 cycles apart.
    task automatic send_pulses(input int n);
        repeat (n) begin
            photon_pulse = 1'b1;
            repeat (3) next_cycle();
            photon_pulse = 1'b0;
            repeat (3) next_cycle();
        end
    endtask

    task automatic send_sync();
        repeat (4) next_cycle();  // Last photon edge clears the synchronizer.
        sync_in = 1'b1;
        repeat (4) next_cycle();
        sync_in = 1'b0;
        repeat (4) next_cycle();  // Fall pulse lands before the next photon.
    endtask

    // One sync period. The record is logged before the edge goes out.
    task automatic run_period(input int n, input logic keep);
        sent_count[frames_sent] = (n > COUNT_MAX) ? '1 : n[`PH_COUNT_W-1:0];
        sent_valid[frames_sent] = keep;  // Dropped records never show.
        send_pulses(n);
        frames_sent++;
        send_sync();
        assert (fall_count == frames_sent)
            else stop_with_error(mismatch_line(test_name,
                                               $sformatf("sync_fall=%0d", frames_sent),
                                               $sformatf("sync_fall=%0d", fall_count)));
    endtask

    task automatic check_overflow(input logic exp_ovf);
        assert (overflow == exp_ovf)
            else stop_with_error(mismatch_line(test_name,
                                               $sformatf("overflow=%0b", exp_ovf),
                                               $sformatf("overflow=%0b", overflow)));
    endtask

    task automatic wait_shown(input int f);
        while (!shown[f]) next_cycle();  // One check per cycle.
    endtask

    task automatic wait_pixels(input int n);
        int target;
        target = pixel_count + n;
        while (pixel_count < target) next_cycle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Display checker.
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [`PH_BUF_AW-1:0]  a;
        logic [`PH_BUF_AW-1:0]  next_addr;
        logic                   exp_f;
        logic [`PH_COUNT_W-1:0] exp_c;
        int                     hit;
        if (rst_n && pixel_valid) begin
            a         = pixel.addr;
            next_addr = prev_addr + 1'b1;
            if (pixel_count == 0) begin
                assert (a == '0)
                    else stop_with_error(mismatch_line(test_name, "addr=0",
                                                       $sformatf("addr=%0d", a)));
            end else begin
                assert (a == next_addr)  // Scan steps by one and wraps.
                    else stop_with_error(mismatch_line(test_name,
                                                       $sformatf("addr=%0d", next_addr),
                                                       $sformatf("addr=%0d", a)));
            end
            // Oldest record still waiting for this address.
            hit = -1;
            for (int f = 0; f < frames_sent; f++) begin
                if (hit < 0 && sent_valid[f] && !shown[f] && f[`PH_BUF_AW-1:0] == a) hit = f;
            end
            exp_f = (hit >= 0) ? 1'b1 : exp_filled[a];
            exp_c = (hit >= 0) ? sent_count[hit] : exp_count[a];
            if (freeze) begin
                // No entry may change while held.
                assert (pixel.filled == exp_filled[a] && pixel.count == exp_count[a])
                    else stop_with_error(mismatch_line(test_name,
                                                       pixel_text(exp_filled[a], exp_count[a]),
                                                       pixel_text(pixel.filled, pixel.count)));
            end else if (hit >= 0 && pixel.filled && pixel.count == sent_count[hit]) begin
                exp_filled[a] = 1'b1;  // Commit on first sight.
                exp_count[a]  = pixel.count;
                shown[hit]    = 1'b1;
            end else begin
                assert (pixel.filled == exp_filled[a] && pixel.count == exp_count[a])
                    else stop_with_error(mismatch_line(test_name, pixel_text(exp_f, exp_c),
                                                       pixel_text(pixel.filled, pixel.count)));
            end
            prev_addr = a;
            pixel_count++;
        end
    end

    always @(negedge clk) begin
        if (rst_n && sync_fall) fall_count++;
    end

    //////////////////////////////////////////////////////////////////////
    // Protocol assertions.
    //////////////////////////////////////////////////////////////////////

    a_fall_isolated : assert property (
        @(posedge clk) disable iff (!rst_n)
        sync_fall |-> !photon_counter_top_inst.photon_rise
    ) else stop_with_error("Sync fall pulse came in the same cycle as a photon rise.");

    a_fall_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        sync_fall |=> !sync_fall
    ) else stop_with_error("Sync fall pulse lasted more than one cycle.");

    a_overflow_sticky : assert property (
        @(posedge clk) disable iff (!rst_n)
        overflow |=> overflow
    ) else stop_with_error("Overflow flag cleared without a reset.");

    // One pixel per 3-cycle loop.
    a_pixel_cadence : assert property (
        @(posedge clk) disable iff (!rst_n)
        pixel_valid |=> !pixel_valid ##1 !pixel_valid ##1 pixel_valid
    ) else stop_with_error("Pixel valid broke the 3-cycle refresh loop.");

    //////////////////////////////////////////////////////////////////////
    // Test sequence and watchdog.
    //////////////////////////////////////////////////////////////////////

    initial begin
        int first_frame;
        void'($urandom(10));
        rst_n        = 1'b0;
        photon_pulse = 1'b0;
        sync_in      = 1'b0;
        freeze       = 1'b0;
        repeat (5) next_cycle();
        rst_n = 1'b1;

        wait_pixels(ENTRIES);  // One full scan of the blank buffer.
        check_overflow(1'b0);

        test_name = "random";
        for (int i = 0; i < RANDOM_PERIODS; i++) begin
            run_period($urandom_range(40, 0), 1'b1);
            wait_shown(frames_sent - 1);
        end

        test_name = "saturate";
        run_period(300, 1'b1);  // Shows as 255.
        wait_shown(frames_sent - 1);
        check_overflow(1'b0);  // FIFO kept draining.

        test_name   = "freeze";
        first_frame = frames_sent;
        freeze      = 1'b1;
        for (int i = 0; i < FREEZE_PERIODS; i++) begin
            run_period(2 + i, i < `PH_FIFO_DEPTH);  // Beyond the depth is lost.
        end
        check_overflow(1'b1);
        freeze = 1'b0;
        for (int f = first_frame; f < first_frame + `PH_FIFO_DEPTH; f++) begin
            wait_shown(f);
        end
        wait_pixels(2 * ENTRIES);  // Dropped addresses keep old contents.
        check_overflow(1'b1);

        $display("TEST PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_error("Timeout, the tests did not finish within the cycle budget.");
    end

endmodule

/* design/photon_counter_top.sv */
`timescale 1ns/100ps

module photon_counter_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       photon_pulse,
    input  logic                       sync_in,
    input  logic                       freeze,
    output logic                       pixel_valid,
    output photon_pkg::display_pixel_t pixel,
    output logic                       overflow,
    output logic                       sync_fall
);

    import photon_pkg::*;

    logic          photon_rise;  // One cycle per photon.
    logic          sync_rise;    // One cycle per period.
    logic          rec_push;
    count_record_t rec;
    logic          fifo_full;
    logic          fifo_empty;
    logic          fifo_pop;
    count_record_t fifo_rec;     // FIFO head.

    //////////////////////////////////////////////////////////////////
    // Input edges.
    //////////////////////////////////////////////////////////////////

    edge_detect u_photon_edge (
        .clk    (clk),
        .rst_n  (rst_n),
        .sig_in (photon_pulse),
        .rise   (photon_rise),
        .fall   ()               // Trailing edge not needed.
    );

    edge_detect u_sync_edge (
        .clk    (clk),
        .rst_n  (rst_n),
        .sig_in (sync_in),
        .rise   (sync_rise),
        .fall   (sync_fall)
    );

    //////////////////////////////////////////////////////////////////
    // Counting, buffering and display.
    //////////////////////////////////////////////////////////////////

    pulse_counter u_pulse_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .photon_rise (photon_rise),
        .sync_rise   (sync_rise),
        .fifo_full   (fifo_full),
        .rec_push    (rec_push),
        .rec         (rec),
        .overflow    (overflow)
    );

    record_fifo u_record_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (rec_push),
        .push_rec (rec),
        .pop      (fifo_pop),
        .pop_rec  (fifo_rec),
        .full     (fifo_full),
        .empty    (fifo_empty)
    );

    frame_buffer u_frame_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .freeze      (freeze),
        .fifo_empty  (fifo_empty),
        .fifo_rec    (fifo_rec),
        .fifo_pop    (fifo_pop),
        .pixel_valid (pixel_valid),
        .pixel       (pixel)
    );

endmodule

/* design/frame_buffer.sv */
`timescale 1ns/100ps
`include "photon_params.svh"

module frame_buffer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       freeze,
    input  logic                       fifo_empty,
    input  photon_pkg::count_record_t  fifo_rec,
    output logic                       fifo_pop,
    output logic                       pixel_valid,
    output photon_pkg::display_pixel_t pixel
);

    import photon_pkg::*;

    localparam int ENTRIES = 1 << `PH_BUF_AW;

    // Sequencer steps.
    localparam logic [1:0] STEP_REFRESH = 2'd0;  // Read one entry out.
    localparam logic [1:0] STEP_DRAW    = 2'd1;  // Commit one record.
    localparam logic [1:0] STEP_LOOP    = 2'd2;  // Back to refresh.

    logic [`PH_COUNT_W-1:0] count_mem [ENTRIES];  // Counts, no reset.
    logic [ENTRIES-1:0]     filled;               // Entry written.
    logic [`PH_BUF_AW-1:0]  scan_ptr;             // Next entry to show.
    logic [1:0]             step;
    logic [`PH_BUF_AW-1:0]  draw_addr;

    assign draw_addr = fifo_rec.frame[`PH_BUF_AW-1:0];  // Frame modulo 16.

    // Draw takes the head record unless held.
    assign fifo_pop = (step == STEP_DRAW) && !freeze && !fifo_empty;

    //////////////////////////////////////////////////////////////////
    // Step machine, scan pointer and filled bits.
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step        <= STEP_REFRESH;
            scan_ptr    <= '0;
            pixel_valid <= 1'b0;
            filled      <= '0;
        end else begin
            pixel_valid <= 1'b0;
            case (step)
                STEP_REFRESH: begin
                    pixel_valid <= 1'b1;              // Pixel out next cycle.
                    scan_ptr    <= scan_ptr + 1'b1;   // Wraps at 16.
                    step        <= STEP_DRAW;
                end
                STEP_DRAW: begin
                    if (fifo_pop) filled[draw_addr] <= 1'b1;
                    step <= STEP_LOOP;
                end
                STEP_LOOP: step <= STEP_REFRESH;
                default:   step <= STEP_REFRESH;  // Unused code.
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////
    // Array write and pixel read.
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fifo_pop) count_mem[draw_addr] <= fifo_rec.count;
        if (step == STEP_REFRESH) begin
            pixel.addr   <= scan_ptr;
            pixel.filled <= filled[scan_ptr];
            // Unwritten entries show zero.
            pixel.count  <= filled[scan_ptr] ? count_mem[scan_ptr] : '0;
        end
    end

    // Pop lands mid loop, the step after it is the loop step.
    a_pop_in_draw : assert property (
        @(posedge clk) disable iff (!rst_n)
        fifo_pop |-> (step == STEP_DRAW) ##1 (step == STEP_LOOP) && !fifo_pop
    );

endmodule

/* design/record_fifo.sv */
`timescale 1ns/100ps
`include "photon_params.svh"

module record_fifo #(
    parameter int DEPTH = `PH_FIFO_DEPTH  // Power of two, two or more.
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push,
    input  photon_pkg::count_record_t push_rec,
    input  logic                      pop,
    output photon_pkg::count_record_t pop_rec,
    output logic                      full,
    output logic                      empty
);

    import photon_pkg::*;

    localparam int             AW       = $clog2(DEPTH);
    localparam logic [AW:0]    FULL_LVL = (AW+1)'(DEPTH);

    count_record_t mem [DEPTH];  // Record storage.
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   level;        // Records held.

    // Pointers and occupancy.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH.
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;       // Both or none.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_rec;
    end

    assign pop_rec = mem[rd_ptr];  // Head shows without a read cycle.
    assign full    = (level == FULL_LVL);
    assign empty   = (level == '0);

    // Producer and consumer obey the levels.
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> !full
    );

    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> !empty
    );

endmodule

/* design/pulse_counter.sv */
`timescale 1ns/100ps
`include "photon_params.svh"

module pulse_counter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      photon_rise,
    input  logic                      sync_rise,
    input  logic                      fifo_full,
    output logic                      rec_push,
    output photon_pkg::count_record_t rec,
    output logic                      overflow
);

    import photon_pkg::*;

    logic [`PH_COUNT_W-1:0] period_cnt;  // Edges in the running period.
    logic [`PH_FRAME_W-1:0] frame_idx;   // Index of the running period.
    count_record_t          rec_q;       // Finished period, waiting to go.
    logic                   pending;     // Record latched last cycle.
    logic                   drop_q;      // Sticky, a record was lost.

    //////////////////////////////////////////////////////////////////
    // Period counting.
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt <= '0;
            frame_idx  <= '0;
            pending    <= 1'b0;
        end else begin
            pending <= sync_rise;  // Push slot is the next cycle.
            if (sync_rise) begin
                // Restart. Coincident edge opens the new period.
                period_cnt <= {{(`PH_COUNT_W-1){1'b0}}, photon_rise};
                frame_idx  <= frame_idx + 1'b1;  // Steps even if dropped.
            end else if (photon_rise && period_cnt != '1) begin
                period_cnt <= period_cnt + 1'b1;  // Saturating.
            end
        end
    end

    // Record payload.
    always_ff @(posedge clk) begin
        if (sync_rise) begin
            rec_q.frame <= frame_idx;
            rec_q.count <= period_cnt;
        end
    end

    //////////////////////////////////////////////////////////////////
    // FIFO push and drop.
    //////////////////////////////////////////////////////////////////

    assign rec_push = pending & ~fifo_full;  // Only with room.
    assign rec      = rec_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_q <= 1'b0;
        end else if (pending && fifo_full) begin
            drop_q <= 1'b1;  // Held until reset.
        end
    end

    assign overflow = drop_q;

    // Push follows a sync edge by one cycle and sees room.
    a_push_slot : assert property (
        @(posedge clk) disable iff (!rst_n)
        rec_push |-> $past(sync_rise) && !fifo_full
    );

endmodule

/* design/edge_detect.sv */
`timescale 1ns/100ps
`include "photon_params.svh"

module edge_detect (
    input  logic clk,
    input  logic rst_n,
    input  logic sig_in,
    output logic rise,
    output logic fall
);

    logic [`PH_SYNC_STAGES-1:0] sync_q;  // Synchronizer chain.
    logic                       last_q;  // Last stage delayed by one cycle.
    logic                       stage_out;

    assign stage_out = sync_q[`PH_SYNC_STAGES-1];  // Settled copy of the input.

    // Chain, edge compare and registered pulses.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
            last_q <= 1'b0;
            rise   <= 1'b0;
            fall   <= 1'b0;
        end else begin
            sync_q[0] <= sig_in;  // First flop may go metastable.
            for (int i = 1; i < `PH_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            last_q <= stage_out;
            rise   <= stage_out & ~last_q;   // Low to high.
            fall   <= ~stage_out & last_q;   // High to low.
        end
    end

    // Pulses never overlap.
    a_pulse_shape : assert property (
        @(posedge clk) disable iff (!rst_n)
        rise |-> !fall
    );

    // Edges at least three cycles apart.
    a_min_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (rise || fall) |=> !(rise || fall) ##1 !(rise || fall)
    );

endmodule

/* design/photon_pkg.sv */
`include "photon_params.svh"

package photon_pkg;

    //////////////////////////////////////////////////////////////////
    // Count record, one per sync period.
    //////////////////////////////////////////////////////////////////

    // Frame index sits in the upper byte.
    // Its low bits pick the buffer entry.
    typedef struct packed {
        logic [`PH_FRAME_W-1:0] frame;  // Period number.
        logic [`PH_COUNT_W-1:0] count;  // Photon edges seen.
    } count_record_t;

    //////////////////////////////////////////////////////////////////
    // Display pixel, one buffer entry on its way out.
    //////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`PH_BUF_AW-1:0]  addr;   // Buffer entry shown.
        logic                   filled; // Entry written since reset.
        logic [`PH_COUNT_W-1:0] count;  // Zero when not filled.
    } display_pixel_t;

    // Record is 16 bits and pixel is 13 bits at default sizes.

endpackage

/* design/photon_params.svh */
`ifndef PHOTON_PARAMS_SVH
`define PHOTON_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Counting core sizes.
//////////////////////////////////////////////////////////////////////

// Photon count per sync period. Saturates at all ones.
`define PH_COUNT_W      8

// Frame index, free running, one step per sync edge.
`define PH_FRAME_W      8

`define PH_BUF_AW       4   // Frame buffer address, 16 entries.
`define PH_FIFO_DEPTH   4   // Record FIFO depth, power of two.

// Synchronizer flops ahead of the edge compare.
`define PH_SYNC_STAGES  2

`endif
